/* all.f */
design/expander_pkg.sv
design/i2c_byte_master.sv
design/pcal6416a_ctrl.sv
design/poll_scheduler.sv
design/expander_top.sv
dv/pcal_bus_model.sv
dv/expander_asserts.sv
dv/expander_tb.sv

/* dv/expander_tb.sv */
// Testbench for expander_top with a behavioral PCAL6416A on the bus
// Runs the row table in order; each row waits for the controller to go idle
`default_nettype none

module expander_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          SCL_HALF    = 2;
    localparam int          POLL_PERIOD = 64;
    localparam logic [6:0]  DEV_ADDR    = 7'h20;
    localparam logic [15:0] DIR_MASK    = 16'hf0f0;
    localparam int          NUM_ROWS    = 9;
    localparam int          CYCLE_LIMIT = NUM_ROWS * 4 * POLL_PERIOD + 2000;

    typedef struct packed {
        logic [15:0] out_value;
        logic [15:0] pins;
        logic [15:0] exp_out;
        logic [15:0] exp_in;     // Input pins only
        logic        read_exp;
        logic [1:0]  exp_writes;
        logic        pause;
        logic [1:0]  polls;
    } row_t;

    logic        clk;
    logic        reset;
    logic        enable;
    logic [6:0]  dev_addr;
    logic [15:0] dir_mask;
    logic [15:0] out_value;
    logic [15:0] pins;
    logic [15:0] in_value;
    logic        in_valid;
    logic        busy;
    logic        scl_oe;
    logic        sda_oe;
    logic        sda_in;
    logic        irq_n;
    logic [15:0] cfg_reg;
    logic [15:0] out_reg;
    int          wr_count;

    row_t        rows [NUM_ROWS];
    string       names [NUM_ROWS];
    integer      seed;
    int          errors;
    int          failed_tests;
    int          assert_errs;
    int          valid_cnt;
    int          paused_act;
    int          cycle_cnt;
    logic [15:0] last_in;

    expander_top #(
        .SCL_HALF   (SCL_HALF),
        .POLL_PERIOD(POLL_PERIOD)
    ) expander_top_i (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .dev_addr (dev_addr),
        .dir_mask (dir_mask),
        .out_value(out_value),
        .irq_n    (irq_n),
        .in_value (in_value),
        .in_valid (in_valid),
        .busy     (busy),
        .scl_oe   (scl_oe),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in)
    );

    pcal_bus_model #(
        .ADDR(DEV_ADDR)
    ) pcal_bus_model_i (
        .scl_oe  (scl_oe),
        .sda_oe  (sda_oe),
        .sda_in  (sda_in),
        .irq_n   (irq_n),
        .pins    (pins),
        .cfg_reg (cfg_reg),
        .out_reg (out_reg),
        .wr_count(wr_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Read strobes, bus activity while disabled, run length
    always @(posedge clk) begin
        if (in_valid) begin
            valid_cnt <= valid_cnt + 1;
            last_in   <= in_value;
        end
        if (!enable && (scl_oe || sda_oe)) begin
            paused_act <= paused_act + 1;
        end
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: controller did not return to idle within %0d cycles", cycle_cnt);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check(input string test, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", test, expected, actual);
            errors++;
        end
    endtask

    task automatic set_row(input int idx, input string name, input logic [15:0] out,
                           input logic [15:0] p, input logic pause, input logic [1:0] polls);
        row_t r;
        r.out_value = out;
        r.pins      = p;
        r.exp_out   = out;
        r.exp_in    = p & DIR_MASK;
        r.pause     = pause;
        r.polls     = polls;
        if (idx == 0) begin
            r.read_exp   = 1'b1;  // Init reads once and writes config and output
            r.exp_writes = 2'd2;
        end else begin
            r.read_exp   = (((p ^ rows[idx-1].pins) & DIR_MASK) != 16'h0000);
            r.exp_writes = {1'b0, out != rows[idx-1].out_value};
        end
        rows[idx]  = r;
        names[idx] = name;
    endtask

    task automatic build_table();
        logic [15:0] p;
        p = 16'($random(seed));
        set_row(0, "init", 16'h1234, p, 1'b0, 2'd1);
        set_row(1, "out_change", 16'ha5c3, p, 1'b0, 2'd1);
        set_row(2, "out_same", 16'ha5c3, p, 1'b0, 2'd1);
        p = p ^ ((16'($random(seed)) & DIR_MASK) | 16'h0010);
        set_row(3, "pin_change", 16'ha5c3, p, 1'b0, 2'd1);
        set_row(4, "quiet", 16'ha5c3, p, 1'b0, 2'd2);
        p = p ^ ((16'($random(seed)) & DIR_MASK) | 16'h1000);
        set_row(5, "out_and_pins", 16'h5a3c, p, 1'b0, 2'd1);
        p = p ^ ((16'($random(seed)) & ~DIR_MASK) | 16'h0001);
        set_row(6, "output_pins_only", 16'h5a3c, p, 1'b0, 2'd1);
        set_row(7, "pause", 16'h0f0f, p, 1'b1, 2'd1);
        p = p ^ ((16'($random(seed)) & DIR_MASK) | 16'h0020);
        set_row(8, "pins_random", 16'h0f0f, p, 1'b0, 2'd1);
    endtask

    task automatic wait_busy(input logic level);
        @(posedge clk);
        while (busy !== level) begin
            @(posedge clk);
        end
    endtask

    task automatic run_row(input int i);
        int errs_before;
        int wr_before;
        int valid_before;
        int act_before;
        errs_before  = errors;
        wr_before    = wr_count;
        valid_before = valid_cnt;
        if (i == 0) begin
            wait_busy(1'b0);  // Init sequence ends when busy drops
        end else begin
            if (rows[i].pause) begin
                enable     <= 1'b0;
                act_before = paused_act;
                repeat (POLL_PERIOD) @(posedge clk);
                out_value <= rows[i].out_value;
                pins      <= rows[i].pins;
                repeat (2 * POLL_PERIOD) @(posedge clk);
                check(names[i], act_before, paused_act);
                check(names[i], rows[i-1].exp_out, out_reg);
                enable <= 1'b1;
            end else begin
                out_value <= rows[i].out_value;
                pins      <= rows[i].pins;
            end
            repeat (4) @(posedge clk);  // Lets irq pass the synchronizer
            check(names[i], !rows[i].read_exp, irq_n);  // Low only for changed input pins
            wait_busy(1'b0);
            for (int k = 0; k < rows[i].polls; k++) begin
                wait_busy(1'b1);
                wait_busy(1'b0);
            end
        end
        if (i == 0) begin
            check(names[i], DIR_MASK, cfg_reg);
        end
        check(names[i], rows[i].exp_out, out_reg);
        check(names[i], rows[i].exp_writes, wr_count - wr_before);
        check(names[i], rows[i].read_exp, valid_cnt - valid_before);
        if (rows[i].read_exp) begin
            check(names[i], rows[i].exp_in, last_in & DIR_MASK);
        end
        check(names[i], 1'b1, irq_n);
        if (errors == errs_before) begin
            $display("%-18s ok", names[i]);
        end else begin
            $display("%-18s FAILED", names[i]);
            failed_tests++;
        end
    endtask

    initial begin
        seed         = 32'h1d44;
        errors       = 0;
        failed_tests = 0;
        build_table();
        reset     = 1'b1;
        enable    = 1'b1;
        dev_addr  = DEV_ADDR;
        dir_mask  = DIR_MASK;
        out_value = rows[0].out_value;
        pins      = rows[0].pins;
        repeat (8) @(posedge clk);
        check("reset", 2'b00, {scl_oe, sda_oe});
        $display("%-18s %s", "reset", (errors == 0) ? "ok" : "FAILED");
        if (errors != 0) begin
            failed_tests++;
        end
        reset <= 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        assert_errs = expander_top_i.pcal6416a_ctrl_i.expander_asserts_i.fail_cnt;
        $display("Totals: %0d tests, %0d failed, %0d check errors, %0d assertion errors",
                 NUM_ROWS + 1, failed_tests, errors, assert_errs);
        if (errors == 0 && assert_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/expander_asserts.sv */
// Handshake assertions for the expander controller, bound into pcal6416a_ctrl
// fail_cnt is read by the testbench at the end of the run
`default_nettype none

module expander_asserts (
    input logic clk,
    input logic reset,
    input logic i2c_start,
    input logic i2c_done,
    input logic in_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    logic outstanding;  // Start seen, done not yet
    int   fail_cnt = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (i2c_start) begin
            outstanding <= 1'b1;
        end else if (i2c_done) begin
            outstanding <= 1'b0;
        end
    end

    start_pulse: assert property (@(posedge clk) disable iff (reset)
        i2c_start |=> !i2c_start)
        else begin
            fail_cnt++;
            $error("i2c_start held longer than one cycle");
        end

    single_outstanding: assert property (@(posedge clk) disable iff (reset)
        outstanding |-> !i2c_start)
        else begin
            fail_cnt++;
            $error("i2c_start issued before i2c_done");
        end

    valid_pulse: assert property (@(posedge clk) disable iff (reset)
        in_valid |=> !in_valid)
        else begin
            fail_cnt++;
            $error("in_valid held longer than one cycle");
        end

endmodule

bind pcal6416a_ctrl expander_asserts expander_asserts_i (
    .clk      (clk),
    .reset    (reset),
    .i2c_start(i2c_start),
    .i2c_done (i2c_done),
    .in_valid (in_valid)
);

`default_nettype wire

/* dv/pcal_bus_model.sv */
// Behavioral PCAL6416A slave for the expander testbench
// Resolves the open-drain bus, holds config and output registers and drives irq_n
`default_nettype none

module pcal_bus_model #(
    parameter logic [6:0] ADDR = 7'h20
) (
    input  logic        scl_oe,
    input  logic        sda_oe,
    output logic        sda_in,
    output logic        irq_n,
    input  logic [15:0] pins,
    output logic [15:0] cfg_reg,
    output logic [15:0] out_reg,
    output int          wr_count   // Transactions that wrote a register
);
    timeunit 1ns;
    timeprecision 100ps;

    logic       scl;
    logic       sda;
    logic       sda_low;
    logic [7:0] regs [0:7];
    logic [15:0] snap;             // Input port as seen at the last read
    logic [7:0] shreg;
    logic [7:0] tx_byte;
    logic [2:0] ptr;
    int         cnt;               // SCL rising edges in the current byte
    logic       first;
    logic       ptr_wr;
    logic       addressed;
    logic       rw;
    logic       tx;
    logic       nack;
    logic       wrote;

    assign scl     = !scl_oe;
    assign sda     = !(sda_oe || sda_low);
    assign sda_in  = sda;
    assign cfg_reg = {regs[7], regs[6]};
    assign out_reg = {regs[3], regs[2]};
    assign irq_n   = (((pins ^ snap) & cfg_reg) == 16'h0000);  // Input pins only

    initial begin
        for (int i = 0; i < 8; i++) begin
            regs[i] = 8'hff;  // Power-up: all pins inputs, outputs high
        end
        snap      = 16'h0000;
        sda_low   = 1'b0;
        cnt       = 0;
        tx        = 1'b0;
        nack      = 1'b0;
        addressed = 1'b0;
        wrote     = 1'b0;
        wr_count  = 0;
    end

    // Start condition
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            cnt       = 0;
            first     = 1'b1;
            tx        = 1'b0;
            nack      = 1'b0;
            addressed = 1'b0;
            wrote     = 1'b0;
            sda_low   = 1'b0;
        end
    end

    // Stop condition
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            if (wrote) begin
                wr_count = wr_count + 1;
            end
            wrote     = 1'b0;
            addressed = 1'b0;
            sda_low   = 1'b0;
        end
    end

    always @(posedge scl) begin
        cnt = cnt + 1;
        if (cnt <= 8 && !tx) begin
            shreg = {shreg[6:0], sda};
        end else if (cnt == 9 && tx) begin
            nack = sda;  // Master ACK slot
        end
    end

    always @(negedge scl) begin
        if (cnt == 8) begin
            if (tx) begin
                sda_low = 1'b0;
            end else begin
                if (first) begin
                    first     = 1'b0;
                    addressed = (shreg[7:1] == ADDR);
                    rw        = shreg[0];
                    ptr_wr    = 1'b1;
                end else if (addressed && ptr_wr) begin
                    ptr    = shreg[2:0];
                    ptr_wr = 1'b0;
                end else if (addressed) begin
                    regs[ptr] = shreg;
                    wrote     = 1'b1;
                    ptr       = {ptr[2:1], ~ptr[0]};  // Toggles within a register pair
                end
                sda_low = addressed;
            end
        end else if (cnt == 9) begin
            cnt     = 0;
            sda_low = 1'b0;
            if (addressed && rw && !nack) begin
                tx = 1'b1;
                if (ptr == 3'd0) begin
                    tx_byte   = (pins[7:0] & regs[6]) | (regs[2] & ~regs[6]);
                    snap[7:0] = pins[7:0];
                end else if (ptr == 3'd1) begin
                    tx_byte    = (pins[15:8] & regs[7]) | (regs[3] & ~regs[7]);
                    snap[15:8] = pins[15:8];
                end else begin
                    tx_byte = regs[ptr];
                end
                ptr     = {ptr[2:1], ~ptr[0]};
                sda_low = !tx_byte[7];
            end
        end else if (tx && cnt >= 1 && cnt <= 7) begin
            sda_low = !tx_byte[7 - cnt];
        end
    end

endmodule

`default_nettype wire

/* design/expander_top.sv */
// PCAL6416A expander subsystem top level
// scl_oe and sda_oe pull the bus lines low, sda_in is the resolved SDA level
`default_nettype none

module expander_top
    import expander_pkg::*;
#(
    parameter int SCL_HALF    = 4,
    parameter int POLL_PERIOD = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        enable,
    input  logic [6:0]  dev_addr,   // Board strap
    input  logic [15:0] dir_mask,
    input  logic [15:0] out_value,
    input  logic        irq_n,
    output logic [15:0] in_value,
    output logic        in_valid,
    output logic        busy,
    output logic        scl_oe,
    output logic        sda_oe,
    input  logic        sda_in
);

    logic     init_req;
    logic     update_req;
    logic     irq;
    logic     i2c_start;
    logic     i2c_done;
    i2c_cmd_t cmd;
    i2c_rsp_t rsp;

    poll_scheduler #(
        .POLL_PERIOD(POLL_PERIOD)
    ) poll_scheduler_i (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .irq_n     (irq_n),
        .init_req  (init_req),
        .update_req(update_req),
        .irq       (irq)
    );

    pcal6416a_ctrl pcal6416a_ctrl_i (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .init_req  (init_req),
        .update_req(update_req),
        .irq       (irq),
        .dev_addr  (dev_addr),
        .dir_mask  (dir_mask),
        .out_value (out_value),
        .in_value  (in_value),
        .in_valid  (in_valid),
        .busy      (busy),
        .cmd       (cmd),
        .i2c_start (i2c_start),
        .i2c_done  (i2c_done),
        .rsp       (rsp)
    );

    i2c_byte_master #(
        .SCL_HALF(SCL_HALF)
    ) i2c_byte_master_i (
        .clk      (clk),
        .reset    (reset),
        .i2c_start(i2c_start),
        .cmd      (cmd),
        .i2c_done (i2c_done),
        .rsp      (rsp),
        .scl_oe   (scl_oe),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in)
    );

endmodule

`default_nettype wire

/* design/poll_scheduler.sv */
// Request generator for the expander controller
// One init request after reset, then an update request every POLL_PERIOD enabled cycles
`default_nettype none

module poll_scheduler #(
    parameter int POLL_PERIOD = 256
) (
    input  logic clk,
    input  logic reset,
    input  logic enable,
    input  logic irq_n,
    output logic init_req,
    output logic update_req,
    output logic irq
);

    localparam int CW = $clog2(POLL_PERIOD);

    logic          init_done;
    logic [CW-1:0] period_cnt;
    logic          irq_meta;

    always_ff @(posedge clk) begin
        if (reset) begin
            init_done  <= 1'b0;
            init_req   <= 1'b0;
            update_req <= 1'b0;
            period_cnt <= '0;
        end else begin
            init_req   <= 1'b0;
            update_req <= 1'b0;
            if (enable) begin
                if (!init_done) begin
                    init_req  <= 1'b1;
                    init_done <= 1'b1;
                end
                if (period_cnt == CW'(POLL_PERIOD - 1)) begin
                    period_cnt <= '0;
                    update_req <= 1'b1;
                end else begin
                    period_cnt <= period_cnt + 1'b1;
                end
            end
        end
    end

    // irq_n is asynchronous to clk
    always_ff @(posedge clk) begin
        if (reset) begin
            irq_meta <= 1'b0;
            irq      <= 1'b0;
        end else begin
            irq_meta <= ~irq_n;
            irq      <= irq_meta;
        end
    end

endmodule

`default_nettype wire

/* design/pcal6416a_ctrl.sv */
// PCAL6416A expander controller
// init_req writes the config registers, update_req rewrites the output port when
// out_value changed and reads the input port when irq is set
`default_nettype none

module pcal6416a_ctrl
    import expander_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        enable,
    input  logic        init_req,
    input  logic        update_req,
    input  logic        irq,
    input  logic [6:0]  dev_addr,
    input  logic [15:0] dir_mask,    // 1 marks an input pin
    input  logic [15:0] out_value,
    output logic [15:0] in_value,
    output logic        in_valid,
    output logic        busy,
    output i2c_cmd_t    cmd,
    output logic        i2c_start,
    input  logic        i2c_done,
    input  i2c_rsp_t    rsp
);

    ctrl_state_t state;

    logic [15:0] last_out;  // Value in the expander output port
    logic        do_read;
    logic        do_write;
    logic        done_pend; // Done seen while disabled
    logic        done_seen;

    assign done_seen = i2c_done || done_pend;
    assign busy      = (state != ST_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_UNINITED;
            last_out  <= ~out_value;  // Forces the first write
            do_read   <= 1'b0;
            do_write  <= 1'b0;
            done_pend <= 1'b0;
            i2c_start <= 1'b0;
            in_valid  <= 1'b0;
        end else begin
            i2c_start <= 1'b0;
            in_valid  <= 1'b0;
            done_pend <= done_seen && !enable;

            if (enable) begin
                case (state)
                    ST_UNINITED: begin
                        if (init_req) begin
                            state <= ST_INIT_WR;
                        end
                    end
                    ST_INIT_WR: begin
                        i2c_start <= 1'b1;
                        state     <= ST_INIT_WAIT;
                    end
                    ST_INIT_WAIT: begin
                        if (done_seen) begin
                            do_read  <= 1'b1;
                            do_write <= 1'b1;
                            state    <= ST_UPDATE;
                        end
                    end
                    ST_IDLE: begin
                        if (update_req) begin
                            do_write <= (out_value != last_out);
                            do_read  <= irq;
                            state    <= ST_UPDATE;
                        end
                    end
                    ST_UPDATE: begin
                        if (do_read) begin
                            state <= ST_PTR;
                        end else if (do_write) begin
                            state <= ST_WRITE;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end
                    ST_WRITE: begin
                        last_out  <= out_value;
                        i2c_start <= 1'b1;
                        state     <= ST_WRITE_WAIT;
                    end
                    ST_WRITE_WAIT: begin
                        if (done_seen) begin
                            do_write <= 1'b0;
                            state    <= ST_UPDATE;
                        end
                    end
                    ST_PTR: begin
                        i2c_start <= 1'b1;
                        state     <= ST_PTR_WAIT;
                    end
                    ST_PTR_WAIT: begin
                        if (done_seen) begin
                            state <= ST_READ;
                        end
                    end
                    ST_READ: begin
                        i2c_start <= 1'b1;
                        state     <= ST_READ_WAIT;
                    end
                    ST_READ_WAIT: begin
                        if (done_seen) begin
                            do_read  <= 1'b0;
                            in_valid <= 1'b1;
                            state    <= ST_UPDATE;
                        end
                    end
                    default: state <= ST_UNINITED;
                endcase
            end
        end
    end

    // Command and read data registers
    always_ff @(posedge clk) begin
        if (enable) begin
            case (state)
                ST_INIT_WR: cmd <= '{dev_addr: dev_addr, num_wr: 2'd3, num_rd: 2'd0,
                                     wr_data: {dir_mask[15:8], dir_mask[7:0], REG_CONFIG0}};
                ST_WRITE:   cmd <= '{dev_addr: dev_addr, num_wr: 2'd3, num_rd: 2'd0,
                                     wr_data: {out_value[15:8], out_value[7:0], REG_OUTPUT0}};
                ST_PTR:     cmd <= '{dev_addr: dev_addr, num_wr: 2'd1, num_rd: 2'd0,
                                     wr_data: {8'h00, 8'h00, REG_INPUT0}};
                ST_READ:    cmd <= '{dev_addr: dev_addr, num_wr: 2'd0, num_rd: 2'd2,
                                     wr_data: '0};
                ST_READ_WAIT: begin
                    if (done_seen) begin
                        in_value <= {rsp.rd_data[1], rsp.rd_data[0]};  // Port 1 is the high byte
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/i2c_byte_master.sv */
// Open-drain I2C master for one transaction of an address byte plus up to three bytes
// Pulse i2c_start with cmd valid; i2c_done pulses when the stop condition is on the bus
// SCL_HALF is the number of clk cycles per SCL half period and must be 2 or more
`default_nettype none

module i2c_byte_master
    import expander_pkg::*;
#(
    parameter int SCL_HALF = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     i2c_start,
    input  i2c_cmd_t cmd,
    output logic     i2c_done,
    output i2c_rsp_t rsp,
    output logic     scl_oe,
    output logic     sda_oe,
    input  logic     sda_in
);

    localparam int CW = $clog2(SCL_HALF + 1);

    i2c_state_t state;
    i2c_cmd_t   cmd_q;

    logic [CW-1:0] tick_cnt;
    logic          tick;
    logic [1:0]    phase;     // Half period index within a state
    logic          last_half;
    logic          step;

    logic [7:0] shreg;
    logic [2:0] bit_cnt;
    logic [1:0] data_idx;
    logic [1:0] next_idx;
    logic [1:0] n_data;
    logic       addr_byte;
    logic       is_read;
    logic       rd_byte;
    logic       more_bytes;

    logic scl_drive;
    logic sda_drive;
    logic sda_q;

    assign tick      = (tick_cnt == CW'(SCL_HALF - 1));
    assign last_half = (state == MS_START) ? (phase == 2'd3) : (phase == 2'd1);
    assign step      = tick && last_half;

    assign rd_byte    = is_read && !addr_byte;
    assign more_bytes = addr_byte ? (n_data != 2'd0) : (data_idx + 2'd1 != n_data);
    assign next_idx   = addr_byte ? 2'd0 : data_idx + 2'd1;

    assign i2c_done = (state == MS_DONE);

    // Line levels for the current half period, 1 pulls the line low
    always_comb begin
        scl_drive = 1'b0;
        sda_drive = 1'b0;
        case (state)
            MS_START: begin
                scl_drive = phase[1];
                sda_drive = (phase != 2'd0);  // SDA falls while SCL is high
            end
            MS_BIT: begin
                scl_drive = !phase[0];
                sda_drive = !rd_byte && !shreg[7];
            end
            MS_ACK: begin
                scl_drive = !phase[0];
                sda_drive = rd_byte && more_bytes;  // NACK on last read byte
            end
            MS_STOP: begin
                scl_drive = !phase[0];
                sda_drive = 1'b1;  // Released in MS_DONE, after SCL is up
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= MS_IDLE;
            tick_cnt <= '0;
            phase    <= 2'd0;
            scl_oe   <= 1'b0;
            sda_q    <= 1'b0;
            sda_oe   <= 1'b0;
        end else begin
            // SDA trails SCL by one clk for hold time on the bus
            scl_oe <= scl_drive;
            sda_q  <= sda_drive;
            sda_oe <= sda_q;

            if (state == MS_IDLE || state == MS_DONE || tick) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end

            if (tick) begin
                phase <= last_half ? 2'd0 : phase + 2'd1;
            end

            case (state)
                MS_IDLE: begin
                    if (i2c_start) begin
                        state <= MS_START;
                    end
                end
                MS_START: begin
                    if (step) begin
                        state <= MS_BIT;
                    end
                end
                MS_BIT: begin
                    if (step && bit_cnt == 3'd7) begin
                        state <= MS_ACK;
                    end
                end
                MS_ACK: begin
                    if (step) begin
                        state <= more_bytes ? MS_BIT : MS_STOP;
                    end
                end
                MS_STOP: begin
                    if (step) begin
                        state <= MS_DONE;
                    end
                end
                default: state <= MS_IDLE;  // MS_DONE lasts one cycle
            endcase
        end
    end

    // Byte datapath, loaded on every start
    always_ff @(posedge clk) begin
        if (state == MS_IDLE && i2c_start) begin
            cmd_q     <= cmd;
            is_read   <= (cmd.num_rd != 2'd0);
            n_data    <= (cmd.num_rd != 2'd0) ? cmd.num_rd : cmd.num_wr;
            shreg     <= {cmd.dev_addr, cmd.num_rd != 2'd0};  // R/W bit
            addr_byte <= 1'b1;
            bit_cnt   <= 3'd0;
            data_idx  <= 2'd0;
        end else if (step) begin
            case (state)
                MS_BIT: begin
                    shreg   <= {shreg[6:0], sda_in};  // Sampled at end of SCL high
                    bit_cnt <= bit_cnt + 3'd1;
                end
                MS_ACK: begin
                    if (rd_byte) begin
                        rsp.rd_data[data_idx[0]] <= shreg;
                    end
                    if (more_bytes) begin
                        shreg <= cmd_q.wr_data[next_idx];
                    end
                    data_idx  <= next_idx;
                    addr_byte <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/expander_pkg.sv */
// Shared types for the PCAL6416A expander subsystem
// Bus command and response structs, register opcodes and FSM state encodings
`default_nettype none

package expander_pkg;

    // One bus transaction, either write-only or read-only
    typedef struct packed {
        logic [6:0]      dev_addr;
        logic [1:0]      num_wr;   // 0 to 3 bytes
        logic [1:0]      num_rd;   // 0 to 2 bytes
        logic [2:0][7:0] wr_data;  // Byte 0 goes out first
    } i2c_cmd_t;

    typedef struct packed {
        logic [1:0][7:0] rd_data;  // Byte 0 arrived first
    } i2c_rsp_t;

    // Expander register pointers
    typedef enum logic [7:0] {
        REG_INPUT0  = 8'h00,
        REG_OUTPUT0 = 8'h02,
        REG_CONFIG0 = 8'h06
    } pcal_reg_t;

    typedef enum logic [3:0] {
        ST_UNINITED,
        ST_INIT_WR,
        ST_INIT_WAIT,
        ST_IDLE,
        ST_UPDATE,
        ST_WRITE,
        ST_WRITE_WAIT,
        ST_PTR,
        ST_PTR_WAIT,
        ST_READ,
        ST_READ_WAIT
    } ctrl_state_t;

    typedef enum logic [2:0] {
        MS_IDLE,
        MS_START,
        MS_BIT,
        MS_ACK,
        MS_STOP,
        MS_DONE
    } i2c_state_t;

endpackage

`default_nettype wire
